/* src.f */
hw/cart_pkg.sv
hw/rom_header_detect.sv
hw/cheat_code_assembler.sv
hw/wram_clear_fill.sv
hw/backup_ram_sequencer.sv
hw/cart_loader.sv
tests/tb_clock.sv
tests/cart_loader_tb.sv

/* tests/cart_loader_tb.sv */
// Cartridge loader testbench with header table, WRAM sweep, cheat record and backup blocks
`timescale 1ns/10ps

module cart_loader_tb;
	import cart_pkg::*;

	localparam int ROWS           = 5;
	localparam int FILL_CYCLES    = 131072;
	localparam int TIMEOUT_CYCLES = ROWS * (FILL_CYCLES + 4000) + 20000;

	logic         clk_sys;
	logic         RESET;
	logic         ioctl_download;
	ioctl_index_t ioctl_index;
	ioctl_addr_t  ioctl_addr;
	ioctl_data_t  ioctl_dout;
	logic         ioctl_wr;
	header_mode_e header_mode;
	logic [1:0]   region_sel;
	wram_init_e   wram_init;
	logic         img_mounted;
	logic         img_readonly;
	logic [63:0]  img_size;
	logic         bk_load_req;
	logic         bk_save_req;
	logic         autosave;
	logic         osd_open;
	logic         bsram_write;
	logic         sd_ack;
	logic [7:0]   rom_type;
	mem_mask_t    rom_mask;
	mem_mask_t    ram_mask;
	logic         pal;
	cheat_code_t  code;
	logic         code_valid;
	fill_addr_t   fill_addr;
	logic [7:0]   fill_data;
	logic         fill_wr;
	sd_lba_t      sd_lba;
	logic         sd_rd;
	logic         sd_wr;
	logic         bk_pending;
	logic         bk_busy;
	logic         core_reset;

	// Stimulus table, one cartridge download per row
	string        row_name [ROWS];
	header_mode_e row_mode [ROWS];
	logic [1:0]   row_region [ROWS];
	wram_init_e   row_init [ROWS];
	ioctl_addr_t  row_hdr_addr [ROWS];
	ioctl_data_t  row_word [ROWS][4];
	logic [7:0]   exp_type [ROWS];
	mem_mask_t    exp_rom [ROWS];
	mem_mask_t    exp_ram [ROWS];
	logic         exp_pal [ROWS];

	string        test_name;
	int           error_count;
	int           cycle_count;
	int           fill_count;
	int           valid_count;
	cheat_code_t  captured_code;
	sd_lba_t      xfer_lba [$];
	logic         xfer_wr [$];
	logic         xfer_rd [$];
	ioctl_data_t  cheat_words [8];

	tb_clock tb_clock_inst (
		.clk_sys(clk_sys)
	);

	cart_loader cart_loader_inst (
		.clk_sys(clk_sys), .RESET(RESET),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
		.header_mode(header_mode), .region_sel(region_sel), .wram_init(wram_init),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_size(img_size),
		.bk_load_req(bk_load_req), .bk_save_req(bk_save_req), .autosave(autosave),
		.osd_open(osd_open), .bsram_write(bsram_write), .sd_ack(sd_ack),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal),
		.code(code), .code_valid(code_valid),
		.fill_addr(fill_addr), .fill_data(fill_data), .fill_wr(fill_wr),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_pending(bk_pending), .bk_busy(bk_busy), .core_reset(core_reset)
	);

	// ============================================================
	// Helpers
	// ============================================================
	task automatic compare_value(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		assert (actual === expected) else begin
			error_count++;
			$display("CHECK FAILED [%s] %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic add_row(input int idx, input string name, input header_mode_e mode,
			input logic [1:0] region, input wram_init_e init, input ioctl_data_t d0,
			input ioctl_data_t d2, input ioctl_addr_t hdr_a, input ioctl_data_t d_rom,
			input ioctl_data_t d_ram, input logic [7:0] typ, input mem_mask_t rmask,
			input mem_mask_t amask, input logic p);
		row_name[idx]     = name;
		row_mode[idx]     = mode;
		row_region[idx]   = region;
		row_init[idx]     = init;
		row_hdr_addr[idx] = hdr_a;
		row_word[idx][0]  = d0;
		row_word[idx][1]  = d2;
		row_word[idx][2]  = d_rom;
		row_word[idx][3]  = d_ram;
		exp_type[idx]     = typ;
		exp_rom[idx]      = rmask;
		exp_ram[idx]      = amask;
		exp_pal[idx]      = p;
	endtask

	task automatic write_word(input ioctl_addr_t a, input ioctl_data_t d);
		@(negedge clk_sys);
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	// Pattern rules per wram_init setting
	function automatic logic [7:0] expected_fill(input wram_init_e mode, input fill_addr_t a);
		case (mode)
			CHECKER_9966: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			STRIPE_00FF:  return (a[9] != a[0]) ? 8'hFF : 8'h00;
			FILL_55:      return 8'h55;
			default:      return 8'hFF;
		endcase
	endfunction

	// One block per ack, numbered from zero, all in one direction
	task automatic verify_transfers(input logic expect_wr, input mem_mask_t mask);
		int blocks;
		int i;
		blocks = int'(mask >> SECTOR_SHIFT) + 1;
		compare_value("block count", blocks, xfer_lba.size());
		for (i = 0; i < xfer_lba.size(); i++) begin
			compare_value("block lba", i, xfer_lba[i]);
			compare_value("block is write", expect_wr, xfer_wr[i]);
			compare_value("block is read", !expect_wr, xfer_rd[i]);
		end
	endtask

	// ============================================================
	// Monitors and block device model
	// ============================================================
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never finished a sweep or transfer",
				cycle_count);
			$display("Test failures found");
			$finish;
		end
	end

	always @(posedge clk_sys) begin
		if (!RESET && fill_wr) begin
			compare_value("fill_addr", fill_addr_t'(fill_count), fill_addr);
			compare_value("fill_data", expected_fill(wram_init, fill_addr_t'(fill_count)),
				fill_data);
			compare_value("core_reset while clearing", 1'b1, core_reset);
			fill_count++;
		end
		if (!RESET && code_valid) begin
			valid_count++;
			captured_code = code;
		end
	end

	initial begin : ack_model
		sd_lba_t     lba_seen;
		int unsigned wait_cycles;
		int unsigned seed_ret;
		seed_ret = $urandom(32'h1769);
		sd_ack   = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (!RESET && (sd_rd || sd_wr)) begin
				lba_seen    = sd_lba;
				wait_cycles = 1 + ($urandom % 4);
				repeat (wait_cycles) @(negedge clk_sys);
				compare_value("sd_lba held", lba_seen, sd_lba);
				xfer_lba.push_back(sd_lba);
				xfer_wr.push_back(sd_wr);
				xfer_rd.push_back(sd_rd);
				sd_ack      = 1'b1;
				wait_cycles = 2 + ($urandom % 7);
				repeat (wait_cycles) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin : main_seq
		int          r;
		int          i;
		cheat_code_t exp_code;
		error_count    = 0;
		cycle_count    = 0;
		fill_count     = 0;
		valid_count    = 0;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = AUTO;
		region_sel     = 2'd0;
		wram_init      = CHECKER_9966;
		img_mounted    = 1'b1;
		img_readonly   = 1'b0;
		img_size       = 64'd0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave       = 1'b0;
		osd_open       = 1'b0;
		bsram_write    = 1'b0;

		add_row(0, "auto_header", AUTO, 2'd0, CHECKER_9966, 16'h0235, 16'h0100,
			LOROM_HDR_ADDR, 16'h0900, 16'h0007, 8'h02, 24'h007FFF, 24'h001FFF, 1'b1);
		add_row(1, "no_header", NO_HEADER, 2'd2, STRIPE_00FF, 16'h0735, 16'h0000,
			LOROM_HDR_ADDR, 16'h0900, 16'h0007, 8'h00, 24'h3FFFFF, 24'h000000, 1'b1);
		add_row(2, "lorom", LOROM, 2'd0, FILL_55, 16'h5F3A, 16'h0000,
			LOROM_HDR_ADDR, 16'h0A00, 16'h0001, 8'h00, 24'h0FFFFF, 24'h0007FF, 1'b0);
		add_row(3, "hirom", HIROM, 2'd3, FILL_FF, 16'h0000, 16'h0000,
			HIROM_HDR_ADDR, 16'h0B00, 16'h0003, 8'h01, 24'h1FFFFF, 24'h001FFF, 1'b1);
		add_row(4, "exhirom", EXHIROM, 2'd0, CHECKER_9966, 16'h0000, 16'h0100,
			EXHIROM_HDR_ADDR, 16'h0D00, 16'h0005, 8'h02, 24'h7FFFFF, 24'h007FFF, 1'b1);

		repeat (10) @(negedge clk_sys);
		RESET     = 1'b0;
		test_name = "reset";
		@(negedge clk_sys);
		compare_value("code_valid", 1'b0, code_valid);
		compare_value("fill_wr", 1'b0, fill_wr);
		compare_value("sd_rd", 1'b0, sd_rd);
		compare_value("sd_wr", 1'b0, sd_wr);
		compare_value("bk_busy", 1'b0, bk_busy);
		compare_value("bk_pending", 1'b0, bk_pending);
		compare_value("core_reset", 1'b0, core_reset);

		for (r = 0; r < ROWS; r++) begin
			test_name      = row_name[r];
			header_mode    = row_mode[r];
			region_sel     = row_region[r];
			wram_init      = row_init[r];
			fill_count     = 0;
			// Odd rows use an upper index bit that the decode ignores
			ioctl_index    = (r % 2) ? 8'h40 : 8'h00;
			ioctl_download = 1'b1;
			write_word(ioctl_addr_t'(0), row_word[r][0]);
			write_word(ioctl_addr_t'(2), row_word[r][1]);
			write_word(row_hdr_addr[r], row_word[r][2]);
			write_word(row_hdr_addr[r] + ioctl_addr_t'(2), row_word[r][3]);
			@(negedge clk_sys);
			ioctl_download = 1'b0;
			repeat (2) @(negedge clk_sys);
			compare_value("rom_type", exp_type[r], rom_type);
			compare_value("rom_mask", exp_rom[r], rom_mask);
			compare_value("ram_mask", exp_ram[r], ram_mask);
			compare_value("pal", exp_pal[r], pal);

			while (fill_wr) @(negedge clk_sys);
			compare_value("fill cycles", FILL_CYCLES, fill_count);
			compare_value("core_reset after clear", 1'b0, core_reset);

			if (exp_ram[r] != '0) begin
				test_name = {row_name[r], " backup"};
				compare_value("bk_pending before write", 1'b0, bk_pending);
				bsram_write = 1'b1;
				@(negedge clk_sys);
				bsram_write = 1'b0;
				@(negedge clk_sys);
				compare_value("bk_pending after write", 1'b1, bk_pending);

				// Save pass
				xfer_lba.delete();
				xfer_wr.delete();
				xfer_rd.delete();
				bk_save_req = 1'b1;
				@(negedge clk_sys);
				bk_save_req = 1'b0;
				while (!bk_busy) @(negedge clk_sys);
				@(negedge clk_sys);
				compare_value("bk_pending once saving", 1'b0, bk_pending);
				while (bk_busy) @(negedge clk_sys);
				verify_transfers(1'b1, exp_ram[r]);

				// Load pass
				xfer_lba.delete();
				xfer_wr.delete();
				xfer_rd.delete();
				bk_load_req = 1'b1;
				@(negedge clk_sys);
				bk_load_req = 1'b0;
				while (!bk_busy) @(negedge clk_sys);
				while (bk_busy) begin
					compare_value("core_reset while loading", 1'b1, core_reset);
					@(negedge clk_sys);
				end
				verify_transfers(1'b0, exp_ram[r]);
			end
		end

		// Cheat record from eight words at offsets 0 to 14
		test_name = "cheat_code";
		for (i = 0; i < 8; i++) begin
			cheat_words[i] = 16'h1111 * (i + 1);
		end
		exp_code = {cheat_words[1], cheat_words[0], cheat_words[3], cheat_words[2],
			cheat_words[5], cheat_words[4], cheat_words[7], cheat_words[6]};
		valid_count    = 0;
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		for (i = 0; i < 8; i++) begin
			write_word(ioctl_addr_t'('h100 + 2 * i), cheat_words[i]);
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_sys);
		compare_value("code_valid pulses", 1, valid_count);
		compare_value("code", exp_code, captured_code);
		compare_value("no sweep from cheat download", 1'b0, fill_wr);

		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
// Testbench clock source, free running clk_sys with an 8 ns period
`timescale 1ns/10ps

module tb_clock (
	output logic clk_sys
);

	localparam real HALF_PERIOD = 4.0;

	initial begin
		clk_sys = 1'b0;
	end

	always begin
		#(HALF_PERIOD) clk_sys = ~clk_sys;
	end

endmodule

/* hw/cart_loader.sv */
// Cartridge loading control, download decode, load edges and core reset
`timescale 1ns/10ps

module cart_loader (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   ioctl_download,
	input  cart_pkg::ioctl_index_t ioctl_index,
	input  cart_pkg::ioctl_addr_t  ioctl_addr,
	input  cart_pkg::ioctl_data_t  ioctl_dout,
	input  logic                   ioctl_wr,
	input  cart_pkg::header_mode_e header_mode,
	input  logic [1:0]             region_sel,
	input  cart_pkg::wram_init_e   wram_init,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic [63:0]            img_size,
	input  logic                   bk_load_req,
	input  logic                   bk_save_req,
	input  logic                   autosave,
	input  logic                   osd_open,
	input  logic                   bsram_write,
	input  logic                   sd_ack,
	output logic [7:0]             rom_type,
	output cart_pkg::mem_mask_t    rom_mask,
	output cart_pkg::mem_mask_t    ram_mask,
	output logic                   pal,
	output cart_pkg::cheat_code_t  code,
	output logic                   code_valid,
	output cart_pkg::fill_addr_t   fill_addr,
	output logic [7:0]             fill_data,
	output logic                   fill_wr,
	output cart_pkg::sd_lba_t      sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   bk_pending,
	output logic                   bk_busy,
	output logic                   core_reset
);
	import cart_pkg::*;

	logic cart_download;
	logic code_download;
	logic cart_download_d;
	logic load_start;
	logic load_end;
	logic clearing;
	logic bk_loading;

	// ============================================================
	// Download decode and load edges
	// ============================================================
	assign cart_download = ioctl_download && ioctl_index[5:0] == CART_INDEX;
	assign code_download = ioctl_download && ioctl_index == CODE_INDEX;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_download_d <= 1'b0;
		end else begin
			cart_download_d <= cart_download;
		end
	end

	assign load_start = cart_download & ~cart_download_d;
	assign load_end   = ~cart_download & cart_download_d;

	// Core stays in reset until every loader stage is idle
	assign core_reset = RESET | cart_download | bk_loading | clearing;

	rom_header_detect rom_header_detect_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_download(cart_download),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ioctl_wr     (ioctl_wr),
		.header_mode  (header_mode),
		.region_sel   (region_sel),
		.rom_type     (rom_type),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.pal          (pal)
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_download(code_download),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ioctl_wr     (ioctl_wr),
		.code         (code),
		.code_valid   (code_valid)
	);

	wram_clear_fill wram_clear_fill_inst (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.load_start(load_start),
		.wram_init (wram_init),
		.fill_addr (fill_addr),
		.fill_data (fill_data),
		.fill_wr   (fill_wr),
		.clearing  (clearing)
	);

	backup_ram_sequencer backup_ram_sequencer_inst (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.load_start   (load_start),
		.load_end     (load_end),
		.cart_download(cart_download),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.ram_mask     (ram_mask),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_pending   (bk_pending),
		.bk_ena       ()
	);

endmodule

/* hw/backup_ram_sequencer.sv */
// Backup RAM save and load sequencer, dirty tracking and block requests
`timescale 1ns/10ps

module backup_ram_sequencer (
	input  logic                clk_sys,
	input  logic                RESET,
	input  logic                load_start,
	input  logic                load_end,
	input  logic                cart_download,
	input  logic                img_mounted,
	input  logic                img_readonly,
	input  logic [63:0]         img_size,
	input  cart_pkg::mem_mask_t ram_mask,
	input  logic                bk_load_req,
	input  logic                bk_save_req,
	input  logic                autosave,
	input  logic                osd_open,
	input  logic                bsram_write,
	input  logic                sd_ack,
	output cart_pkg::sd_lba_t   sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic                bk_busy,
	output logic                bk_loading,
	output logic                bk_pending,
	output logic                bk_ena
);
	import cart_pkg::*;

	logic    load_q;
	logic    save_q;
	logic    old_load;
	logic    old_save;
	logic    old_ack;
	logic    ack_rise;
	logic    ack_fall;
	sd_lba_t last_lba;

	// ============================================================
	// Enable and dirty tracking
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (RESET || load_start) begin
			bk_ena <= 1'b0;
		end else if (cart_download && img_mounted && !img_readonly) begin
			bk_ena <= |ram_mask;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_open && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy || !bk_ena) begin
			bk_pending <= 1'b0;
		end
	end

	// ============================================================
	// Block sequencer
	// ============================================================
	assign load_q   = bk_load_req & bk_ena;
	assign save_q   = (bk_save_req | (bk_pending & osd_open & autosave)) & bk_ena;
	assign ack_rise = sd_ack & ~old_ack;
	assign ack_fall = old_ack & ~sd_ack;
	assign last_lba = sd_lba_t'(ram_mask >> SECTOR_SHIFT);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= load_q;
			old_save <= save_q;
			old_ack  <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if ((load_q && !old_load) || (save_q && !old_save)) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_q;
					sd_lba     <= '0;
					sd_rd      <= load_q;
					sd_wr      <= ~load_q;
				end
				// Reload the save file once the image is in
				if (load_end && img_size != 64'd0 && bk_ena) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (ack_fall) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + sd_lba_t'(1);
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

endmodule

/* hw/wram_clear_fill.sv */
// Work RAM clear sweep with a selectable power-on fill pattern
`timescale 1ns/10ps

module wram_clear_fill (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 load_start,
	input  cart_pkg::wram_init_e wram_init,
	output cart_pkg::fill_addr_t fill_addr,
	output logic [7:0]           fill_data,
	output logic                 fill_wr,
	output logic                 clearing
);
	import cart_pkg::*;

	logic sweep_done;

	assign sweep_done = clearing & (&fill_addr);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing <= 1'b0;
		end else if (sweep_done) begin
			clearing <= 1'b0;
		end else if (load_start) begin
			clearing <= 1'b1;
		end
	end

	// Counter idles at zero so the next sweep starts from the bottom
	always_ff @(posedge clk_sys) begin
		if (RESET || !clearing) begin
			fill_addr <= '0;
		end else begin
			fill_addr <= fill_addr + fill_addr_t'(1);
		end
	end

	assign fill_wr = clearing;

	// ============================================================
	// Fill pattern
	// ============================================================
	always_comb begin
		case (wram_init)
			CHECKER_9966: fill_data = (fill_addr[8] ^ fill_addr[2]) ? PAT_66 : PAT_99;
			STRIPE_00FF:  fill_data = (fill_addr[9] ^ fill_addr[0]) ? PAT_FF : PAT_00;
			FILL_55:      fill_data = PAT_55;
			default:      fill_data = PAT_FF;
		endcase
	end

endmodule

/* hw/cheat_code_assembler.sv */
// Cheat record assembler, packs eight download words into one code and strobes it
`timescale 1ns/10ps

module cheat_code_assembler (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  code_download,
	input  cart_pkg::ioctl_addr_t ioctl_addr,
	input  cart_pkg::ioctl_data_t ioctl_dout,
	input  logic                  ioctl_wr,
	output cart_pkg::cheat_code_t code,
	output logic                  code_valid
);

	logic       code_wr;
	logic [3:0] word_ofs;

	assign code_wr  = code_download & ioctl_wr;
	assign word_ofs = ioctl_addr[3:0];

	// Low half of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word_ofs)
				4'd0:  code[111:96]  <= ioctl_dout;
				4'd2:  code[127:112] <= ioctl_dout;
				4'd4:  code[79:64]   <= ioctl_dout;
				4'd6:  code[95:80]   <= ioctl_dout;
				4'd8:  code[47:32]   <= ioctl_dout;
				4'd10: code[63:48]   <= ioctl_dout;
				4'd12: code[15:0]    <= ioctl_dout;
				4'd14: code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of the record completes it
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
		end else begin
			code_valid <= code_wr && word_ofs == 4'd14;
		end
	end

endmodule

/* hw/rom_header_detect.sv */
// ROM header detection for mapping type, ROM and RAM size masks and video region
`timescale 1ns/10ps

module rom_header_detect (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_download,
	input  cart_pkg::ioctl_addr_t  ioctl_addr,
	input  cart_pkg::ioctl_data_t  ioctl_dout,
	input  logic                   ioctl_wr,
	input  cart_pkg::header_mode_e header_mode,
	input  logic [1:0]             region_sel,
	output logic [7:0]             rom_type,
	output cart_pkg::mem_mask_t    rom_mask,
	output cart_pkg::mem_mask_t    ram_mask,
	output logic                   pal
);
	import cart_pkg::*;

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic        hdr_forced;
	ioctl_addr_t hdr_addr;
	logic        hdr_wr;

	// Size byte location when the mapping is forced by the user
	always_comb begin
		hdr_forced = 1'b1;
		case (header_mode)
			LOROM:   hdr_addr = LOROM_HDR_ADDR;
			HIROM:   hdr_addr = HIROM_HDR_ADDR;
			EXHIROM: hdr_addr = EXHIROM_HDR_ADDR;
			default: begin
				hdr_forced = 1'b0;
				hdr_addr   = '0;
			end
		endcase
	end

	assign hdr_wr = cart_download & ioctl_wr;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			// First word carries the loader's own size and type bytes
			if (ioctl_addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				if (header_mode == AUTO && ioctl_dout[7:0] != 8'd0) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end
				case (header_mode)
					HIROM:   rom_type <= 8'd1;
					EXHIROM: rom_type <= 8'd2;
					AUTO:    rom_type <= ioctl_dout[15:8];
					default: rom_type <= 8'd0;
				endcase
			end

			if (ioctl_addr == ioctl_addr_t'(2)) begin
				rom_region <= ioctl_dout[8];
			end

			// Forced modes read the sizes out of the cartridge header
			if (hdr_forced && ioctl_addr == hdr_addr) begin
				rom_size <= ioctl_dout[11:8];
			end
			if (hdr_forced && ioctl_addr == hdr_addr + ioctl_addr_t'(2)) begin
				ram_size <= ioctl_dout[3:0];
			end
		end
	end

	// Masks track the size registers directly
	assign rom_mask = (mem_mask_t'(MASK_UNIT) << rom_size) - mem_mask_t'(1);
	assign ram_mask = (ram_size == 4'd0) ? '0
		: (mem_mask_t'(MASK_UNIT) << ram_size) - mem_mask_t'(1);

	// Region select 0 means follow the image
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

/* hw/cart_pkg.sv */
// Cartridge loader package with download widths, types, index codes and header constants
package cart_pkg;

	// ============================================================
	// Download stream
	// ============================================================
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;

	typedef logic [IOCTL_ADDR_W-1:0] ioctl_addr_t;
	typedef logic [IOCTL_DATA_W-1:0] ioctl_data_t;
	typedef logic [7:0]              ioctl_index_t;
	typedef logic [23:0]             mem_mask_t;

	// Low six index bits of a ROM image, full index of a cheat file
	localparam logic [5:0]   CART_INDEX = 6'd0;
	localparam ioctl_index_t CODE_INDEX = '1;

	// ============================================================
	// Image header
	// ============================================================
	localparam int HEADER_SKIP = 512;

	// Size byte pair for each forced mapping, RAM size word sits 2 bytes higher
	localparam ioctl_addr_t LOROM_HDR_ADDR   = ioctl_addr_t'('h7FD6 + HEADER_SKIP);
	localparam ioctl_addr_t HIROM_HDR_ADDR   = ioctl_addr_t'('hFFD6 + HEADER_SKIP);
	localparam ioctl_addr_t EXHIROM_HDR_ADDR = ioctl_addr_t'('h40FFD6 + HEADER_SKIP);

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'd12;
	localparam int         MASK_UNIT        = 1024;

	typedef enum logic [2:0] {
		AUTO      = 3'd0,
		NO_HEADER = 3'd1,
		LOROM     = 3'd2,
		HIROM     = 3'd3,
		EXHIROM   = 3'd4
	} header_mode_e;

	// ============================================================
	// Work RAM fill and backup RAM
	// ============================================================
	localparam int FILL_ADDR_W = 17;
	typedef logic [FILL_ADDR_W-1:0] fill_addr_t;

	typedef enum logic [1:0] {
		CHECKER_9966 = 2'd0,
		STRIPE_00FF  = 2'd1,
		FILL_55      = 2'd2,
		FILL_FF      = 2'd3
	} wram_init_e;

	localparam logic [7:0] PAT_00 = 8'h00;
	localparam logic [7:0] PAT_55 = 8'h55;
	localparam logic [7:0] PAT_66 = 8'h66;
	localparam logic [7:0] PAT_99 = 8'h99;
	localparam logic [7:0] PAT_FF = 8'hFF;

	// {flags, address, compare, replace}, 32 bits each
	typedef logic [127:0] cheat_code_t;

	typedef logic [31:0] sd_lba_t;
	localparam int SECTOR_SHIFT = 9;

endpackage
